//--- hdl/net_cfg_pkg.sv
package net_cfg_pkg;

    // Header field types seen by the echo logic
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;

    // Address of this node is 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {
        8'd192,
        8'd168,
        8'd1,
        8'd128
    };

    // Only datagrams to this port are echoed
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // TTL placed in every reply
    localparam ttl_t REPLY_TTL = 8'd64;

endpackage

//--- hdl/stream_pkg.sv
package stream_pkg;

    // Payload bus geometry
    localparam int DATA_BYTES = 8;
    localparam int DATA_W     = DATA_BYTES * 8;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;

    // One payload beat as held in the FIFO
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } beat_t;

    // 16 beats of buffering
    localparam int FIFO_ADDR_W = 4;

    typedef logic [7:0] led_t;

endpackage

//--- hdl/udp_stream_if.sv
`timescale 1ns/1ns

interface udp_stream_if;
    import stream_pkg::*;

    data_t data;
    keep_t keep;
    logic  valid;
    logic  ready;
    logic  last;
    logic  user;

    // Producer side
    modport source (
        output data, keep, valid, last, user,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data, keep, valid, last, user,
        output ready
    );

    // Passive observer of the whole bus
    modport monitor (
        input data, keep, valid, ready, last, user
    );

endinterface

//--- hdl/udp_echo_steer.sv
`timescale 1ns/1ns

module udp_echo_steer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  net_cfg_pkg::ip_addr_t  rx_src_ip,
    input  net_cfg_pkg::udp_port_t rx_src_port,
    input  net_cfg_pkg::udp_port_t rx_dst_port,
    input  net_cfg_pkg::udp_len_t  rx_length,
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output net_cfg_pkg::ip_addr_t  tx_src_ip,
    output net_cfg_pkg::ip_addr_t  tx_dst_ip,
    output net_cfg_pkg::udp_port_t tx_src_port,
    output net_cfg_pkg::udp_port_t tx_dst_port,
    output net_cfg_pkg::udp_len_t  tx_length,
    output net_cfg_pkg::ttl_t      tx_ttl,
    input  stream_pkg::data_t      rx_payload_data,
    input  stream_pkg::keep_t      rx_payload_keep,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,
    udp_stream_if.source           out_stream
);
    import net_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_KEEP,
        ST_DROP
    } state_t;

    state_t state;
    logic   port_match;
    logic   idle;
    logic   hdr_xfer;
    logic   last_xfer;

    assign port_match = (rx_dst_port == ECHO_PORT);
    assign idle       = (state == ST_IDLE);

    // Header handshake only while no frame is in flight
    assign tx_hdr_valid = rx_hdr_valid & port_match & idle;
    assign rx_hdr_ready = idle & (port_match ? tx_hdr_ready : 1'b1);
    assign hdr_xfer     = rx_hdr_valid & rx_hdr_ready;

    // Reply header with addresses and ports swapped
    assign tx_src_ip   = LOCAL_IP;
    assign tx_dst_ip   = rx_src_ip;
    assign tx_src_port = rx_dst_port;
    assign tx_dst_port = rx_src_port;
    assign tx_length   = rx_length;
    assign tx_ttl      = REPLY_TTL;

    // Payload goes to the FIFO for kept frames
    assign out_stream.data  = rx_payload_data;
    assign out_stream.keep  = rx_payload_keep;
    assign out_stream.last  = rx_payload_last;
    assign out_stream.user  = rx_payload_user;
    assign out_stream.valid = rx_payload_valid & (state == ST_KEEP);

    // Dropped frames drain at full rate
    assign rx_payload_ready = (state == ST_KEEP) ? out_stream.ready : (state == ST_DROP);
    assign last_xfer        = rx_payload_valid & rx_payload_ready & rx_payload_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_KEEP : ST_DROP;
                    end
                end
                ST_KEEP, ST_DROP: begin
                    if (last_xfer) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
    parameter int ADDR_W = stream_pkg::FIFO_ADDR_W
) (
    input  logic         clk,
    input  logic         rst,
    udp_stream_if.sink   in_stream,
    udp_stream_if.source out_stream
);
    import stream_pkg::*;

    beat_t mem [2**ADDR_W];

    // Extra top bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic  full;
    logic  empty;
    logic  wr_en;
    logic  rd_en;
    beat_t wr_beat;
    beat_t rd_beat;

    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_stream.ready = ~full;
    assign wr_en           = in_stream.valid & ~full;
    assign rd_en           = out_stream.valid & out_stream.ready;

    always_comb begin
        wr_beat.data = in_stream.data;
        wr_beat.keep = in_stream.keep;
        wr_beat.last = in_stream.last;
        wr_beat.user = in_stream.user;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry stays put until it is taken
    assign rd_beat = mem[rd_ptr[ADDR_W-1:0]];

    assign out_stream.valid = ~empty;
    assign out_stream.data  = rd_beat.data;
    assign out_stream.keep  = rd_beat.keep;
    assign out_stream.last  = rd_beat.last;
    assign out_stream.user  = rd_beat.user;

endmodule

//--- hdl/led_first_byte.sv
`timescale 1ns/1ns

module led_first_byte (
    input  logic             clk,
    input  logic             rst,
    udp_stream_if.monitor    mon,
    output stream_pkg::led_t led
);
    import stream_pkg::*;

    // Set while the rest of a frame is still to come
    logic in_frame;
    logic xfer;

    assign xfer = mon.valid & mon.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (xfer) begin
            if (!in_frame) begin
                led <= mon.data[$bits(led_t)-1:0];
            end
            // Single-beat frames never set the flag
            in_frame <= ~mon.last;
        end
    end

endmodule

//--- hdl/udp_echo_core.sv
`timescale 1ns/1ns

module udp_echo_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  net_cfg_pkg::ip_addr_t  rx_src_ip,
    input  net_cfg_pkg::udp_port_t rx_src_port,
    input  net_cfg_pkg::udp_port_t rx_dst_port,
    input  net_cfg_pkg::udp_len_t  rx_length,
    input  stream_pkg::data_t      rx_payload_data,
    input  stream_pkg::keep_t      rx_payload_keep,
    input  logic                   rx_payload_valid,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,
    output logic                   rx_payload_ready,
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output net_cfg_pkg::ip_addr_t  tx_src_ip,
    output net_cfg_pkg::ip_addr_t  tx_dst_ip,
    output net_cfg_pkg::udp_port_t tx_src_port,
    output net_cfg_pkg::udp_port_t tx_dst_port,
    output net_cfg_pkg::udp_len_t  tx_length,
    output net_cfg_pkg::ttl_t      tx_ttl,
    output stream_pkg::data_t      tx_payload_data,
    output stream_pkg::keep_t      tx_payload_keep,
    output logic                   tx_payload_valid,
    output logic                   tx_payload_last,
    output logic                   tx_payload_user,
    input  logic                   tx_payload_ready,
    output stream_pkg::led_t       led
);
    import stream_pkg::*;

    udp_stream_if steer_to_fifo ();
    udp_stream_if fifo_out ();

    udp_echo_steer steer0 (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_src_ip        (rx_src_ip),
        .rx_src_port      (rx_src_port),
        .rx_dst_port      (rx_dst_port),
        .rx_length        (rx_length),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_src_ip        (tx_src_ip),
        .tx_dst_ip        (tx_dst_ip),
        .tx_src_port      (tx_src_port),
        .tx_dst_port      (tx_dst_port),
        .tx_length        (tx_length),
        .tx_ttl           (tx_ttl),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_keep  (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .out_stream       (steer_to_fifo.source)
    );

    stream_fifo #(
        .ADDR_W (FIFO_ADDR_W)
    ) fifo0 (
        .clk        (clk),
        .rst        (rst),
        .in_stream  (steer_to_fifo.sink),
        .out_stream (fifo_out.source)
    );

    // Output port is the sink of the FIFO stream
    assign tx_payload_data  = fifo_out.data;
    assign tx_payload_keep  = fifo_out.keep;
    assign tx_payload_valid = fifo_out.valid;
    assign tx_payload_last  = fifo_out.last;
    assign tx_payload_user  = fifo_out.user;
    assign fifo_out.ready   = tx_payload_ready;

    led_first_byte led0 (
        .clk (clk),
        .rst (rst),
        .mon (fifo_out.monitor),
        .led (led)
    );

endmodule

//--- dv/udp_echo_props.sv
`timescale 1ns/1ns

module udp_echo_props (
    input logic                   clk,
    input logic                   rst,
    input net_cfg_pkg::ip_addr_t  rx_src_ip,
    input net_cfg_pkg::udp_port_t rx_src_port,
    input net_cfg_pkg::udp_port_t rx_dst_port,
    input net_cfg_pkg::udp_len_t  rx_length,
    input logic                   tx_hdr_valid,
    input net_cfg_pkg::ip_addr_t  tx_src_ip,
    input net_cfg_pkg::ip_addr_t  tx_dst_ip,
    input net_cfg_pkg::udp_port_t tx_src_port,
    input net_cfg_pkg::udp_port_t tx_dst_port,
    input net_cfg_pkg::udp_len_t  tx_length,
    input net_cfg_pkg::ttl_t      tx_ttl,
    input stream_pkg::data_t      tx_payload_data,
    input stream_pkg::keep_t      tx_payload_keep,
    input logic                   tx_payload_valid,
    input logic                   tx_payload_ready,
    input logic                   tx_payload_last,
    input logic                   tx_payload_user,
    input stream_pkg::led_t       led
);
    import net_cfg_pkg::*;

    // Number of property failures so far
    int unsigned fail_count = 0;

    // Reply header built from the received one
    assert property (@(posedge clk) tx_hdr_valid |->
        (tx_dst_ip == rx_src_ip && tx_src_ip == LOCAL_IP &&
         tx_src_port == rx_dst_port && tx_dst_port == rx_src_port &&
         tx_length == rx_length && tx_ttl == REPLY_TTL))
        else begin
            $error("reply header fields wrong");
            fail_count++;
        end

    // No reply for other ports
    assert property (@(posedge clk) tx_hdr_valid |-> rx_dst_port == ECHO_PORT)
        else begin
            $error("reply header for a foreign port");
            fail_count++;
        end

    // Outputs quiet during and right after reset
    assert property (@(posedge clk) rst |=> (!tx_payload_valid && led == '0))
        else begin
            $error("payload valid or led set after reset");
            fail_count++;
        end

    // Stalled output beat holds still
    assert property (@(posedge clk) disable iff (rst)
        (tx_payload_valid && !tx_payload_ready) |=>
        (tx_payload_valid && $stable(tx_payload_data) && $stable(tx_payload_keep) &&
         $stable(tx_payload_last) && $stable(tx_payload_user)))
        else begin
            $error("output beat changed while stalled");
            fail_count++;
        end

endmodule

bind udp_echo_core udp_echo_props props0 (.*);

//--- dv/udp_echo_tb.sv
`timescale 1ns/1ns

module udp_echo_tb;
    import net_cfg_pkg::*;
    import stream_pkg::*;

    localparam int N_FRAMES   = 40;
    localparam int MAX_CYCLES = 2500;

    logic      clk = 1'b0;
    logic      rst;
    logic      rx_hdr_valid, rx_hdr_ready, tx_hdr_valid, tx_hdr_ready;
    ip_addr_t  rx_src_ip, tx_src_ip, tx_dst_ip;
    udp_port_t rx_src_port, rx_dst_port, tx_src_port, tx_dst_port;
    udp_len_t  rx_length, tx_length;
    ttl_t      tx_ttl;
    data_t     rx_payload_data, tx_payload_data;
    keep_t     rx_payload_keep, tx_payload_keep;
    logic      rx_payload_valid, rx_payload_ready, rx_payload_last, rx_payload_user;
    logic      tx_payload_valid, tx_payload_ready, tx_payload_last, tx_payload_user;
    led_t      led;

    beat_t exp_q[$];
    led_t  led_expect;
    logic  first_beat;
    int    cycle_count;
    int    stall_left;

    udp_echo_core dut0 (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    // Random back-pressure with occasional long stalls that fill the FIFO
    always @(negedge clk) begin
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
            tx_payload_ready = 1'b0;
        end else if ($urandom % 60 == 0) begin
            stall_left = 80;
            tx_payload_ready = 1'b0;
        end else begin
            tx_payload_ready = ($urandom % 4) != 0;
        end
        tx_hdr_ready = ($urandom % 3) != 0;
    end

    task automatic send_frame(input logic keep_it);
        int unsigned n_beats;
        udp_port_t   dport;
        beat_t       b;
        n_beats = 1 + ($urandom % 6);
        dport = keep_it ? ECHO_PORT : udp_port_t'($urandom);
        if (!keep_it && dport == ECHO_PORT)
            dport = dport + 16'd1;
        @(negedge clk);
        rx_src_ip    = $urandom;
        rx_src_port  = udp_port_t'($urandom);
        rx_dst_port  = dport;
        rx_length    = udp_len_t'(8 + n_beats * 8);
        rx_hdr_valid = 1'b1;
        // Only echoed headers wait for the reply side
        do begin
            @(posedge clk);
            assert (tx_hdr_valid == keep_it) else abort_run($sformatf(
                "** Error: %0t ns: tx_hdr_valid %b for port %0d", $time, tx_hdr_valid, dport));
            assert (rx_hdr_ready == (keep_it ? tx_hdr_ready : 1'b1)) else abort_run($sformatf(
                "** Error: %0t ns: rx_hdr_ready %b with tx_hdr_ready %b for port %0d",
                $time, rx_hdr_ready, tx_hdr_ready, dport));
        end while (!rx_hdr_ready);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < n_beats; i++) begin
            // Occasional idle cycle between beats
            if ($urandom % 4 == 0)
                @(negedge clk);
            b.data = {$urandom, $urandom};
            b.last = (i == n_beats - 1);
            b.keep = b.last ? keep_t'(1 + ($urandom % 255)) : '1;
            b.user = $urandom % 2;
            {rx_payload_data, rx_payload_keep, rx_payload_last, rx_payload_user} = b;
            rx_payload_valid = 1'b1;
            @(posedge clk);
            assert (keep_it || rx_payload_ready)
                else abort_run("A beat of a dropped frame was not taken at once");
            while (!rx_payload_ready) @(posedge clk);
            if (keep_it)
                exp_q.push_back(b);
            @(negedge clk);
            rx_payload_valid = 1'b0;
        end
    endtask

    // Scoreboard on the output stream and the LED
    always @(posedge clk) begin : check_output
        beat_t got;
        beat_t want;
        if (!rst) begin
            assert (led == led_expect) else abort_run($sformatf(
                "** Error: %0t ns: led %h, expected %h", $time, led, led_expect));
            if (tx_payload_valid && tx_payload_ready) begin
                got = {tx_payload_data, tx_payload_keep, tx_payload_last, tx_payload_user};
                assert (exp_q.size() != 0)
                    else abort_run("A payload beat came out that no kept frame sent");
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (got == want) else abort_run($sformatf(
                        "** Error: %0t ns: beat %h, expected %h", $time, got, want));
                    if (first_beat)
                        led_expect = led_t'(got.data);
                    first_beat = got.last;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run("Timeout, the run did not finish within 2500 cycles");
    end

    always @(negedge clk) begin
        if (dut0.props0.fail_count != 0)
            abort_run("A bound property check on the DUT failed");
    end

    initial begin
        void'($urandom(47782));
        cycle_count = 0;
        stall_left = 0;
        first_beat = 1'b1;
        led_expect = '0;
        rst = 1'b1;
        {rx_hdr_valid, rx_src_ip, rx_src_port, rx_dst_port, rx_length} = '0;
        {rx_payload_data, rx_payload_keep, rx_payload_valid} = '0;
        {rx_payload_last, rx_payload_user, tx_hdr_ready, tx_payload_ready} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < N_FRAMES; f++)
            send_frame(($urandom % 2) == 0);
        while (tx_payload_valid) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("Expected beats never came out of the DUT");
        end
    end

endmodule

//--- build.f
hdl/net_cfg_pkg.sv
hdl/stream_pkg.sv
hdl/udp_stream_if.sv
hdl/udp_echo_steer.sv
hdl/stream_fifo.sv
hdl/led_first_byte.sv
hdl/udp_echo_core.sv
dv/udp_echo_props.sv
dv/udp_echo_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module udp_echo_tb -Mdir obj_dir &&
{ ./obj_dir/Vudp_echo_tb +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "Test passed" sim.log &&
exit 0 || exit 1
